// ==== ooo.f ====
source/ooo_pkg.sv
source/rat.sv
source/prf.sv
source/rs.sv
source/rob.sv
source/fu_cdb.sv
source/ooo.sv
verif/ooo_tb.sv

// ==== source/fu_cdb.sv ====
module fu_cdb (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   alu_issue_valid,
    input  logic                   mult_issue_valid,
    input  ooo_pkg::issue_packet_t issue,
    output logic                   alu_avail,
    output logic                   mult_avail,
    output ooo_pkg::cdb_packet_t   cdb
);
    import ooo_pkg::*;

    logic            alu_valid;
    issue_packet_t   alu_q;
    logic [XLEN-1:0] alu_result;
    cdb_packet_t     mult_pipe [MULT_STAGES];

    always_comb begin
        case (alu_q.op)
            OP_LI:   alu_result = XLEN'(alu_q.imm);
            OP_ADD:  alu_result = alu_q.opa + alu_q.opb;
            OP_SUB:  alu_result = alu_q.opa - alu_q.opb;
            OP_XOR:  alu_result = alu_q.opa ^ alu_q.opb;
            default: alu_result = '0;
        endcase
    end

    // hold off the alu one cycle ahead of a multiplier broadcast
    assign alu_avail  = !mult_pipe[MULT_STAGES-2].valid;
    assign mult_avail = 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            cdb       <= '0;
            for (int s = 0; s < MULT_STAGES; s++) begin
                mult_pipe[s].valid <= 1'b0;
            end
        end else begin
            alu_valid <= alu_issue_valid;
            if (alu_issue_valid) begin
                alu_q <= issue;
            end

            // low half of the product only
            mult_pipe[0] <= '{valid: mult_issue_valid, dest_prn: issue.dest_prn,
                              robn: issue.robn, value: issue.opa * issue.opb};
            for (int s = 1; s < MULT_STAGES; s++) begin
                mult_pipe[s] <= mult_pipe[s-1];
            end

            // multiplier cannot stall so it always wins
            if (mult_pipe[MULT_STAGES-1].valid) begin
                cdb <= mult_pipe[MULT_STAGES-1];
            end else begin
                cdb <= '{valid: alu_valid, dest_prn: alu_q.dest_prn,
                         robn: alu_q.robn, value: alu_result};
            end
        end
    end

    a_no_bus_clash: assert property (@(posedge clock) disable iff (!rst_n)
        !(alu_valid && mult_pipe[MULT_STAGES-1].valid));

endmodule

// ==== source/ooo.sv ====
module ooo (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      dispatch_valid,
    input  ooo_pkg::dispatch_packet_t dispatch,
    output logic                      structural_hazard,
    output logic                      commit_valid,
    output ooo_pkg::commit_packet_t   commit
);
    import ooo_pkg::*;

    prn_t            src1_prn, src2_prn, old_prn, dest_prn;
    logic            free_empty, rs_full, rob_full;
    logic [XLEN-1:0] rd1_value, rd2_value, commit_value;
    logic            rd1_ready, rd2_ready;
    logic            opa_hit, opb_hit;
    rs_entry_t       rs_entry;
    rob_entry_t      rob_entry;
    robn_t           rob_tail;
    commit_packet_t  rob_commit;
    issue_packet_t   issue;
    logic            alu_issue_valid, mult_issue_valid;
    logic            alu_avail, mult_avail;
    cdb_packet_t     cdb;

    rat u_rat (
        .clock, .rst_n, .dispatch_valid, .dispatch,
        .commit_valid, .commit(rob_commit),
        .src1_prn, .src2_prn, .old_prn, .dest_prn, .free_empty
    );

    prf u_prf (
        .clock, .rst_n, .rd1_prn(src1_prn), .rd2_prn(src2_prn),
        .commit_prn(rob_commit.dest_prn), .alloc_prn(dest_prn),
        .alloc_valid(dispatch_valid), .cdb,
        .rd1_value, .rd2_value, .commit_value, .rd1_ready, .rd2_ready
    );

    rs u_rs (
        .clock, .rst_n, .dispatch_valid, .entry_in(rs_entry), .cdb,
        .alu_avail, .mult_avail, .alu_issue_valid, .mult_issue_valid,
        .issue, .full(rs_full)
    );

    rob u_rob (
        .clock, .rst_n, .dispatch_valid, .entry_in(rob_entry), .cdb,
        .tail(rob_tail), .full(rob_full), .commit_valid, .commit(rob_commit)
    );

    fu_cdb u_fu_cdb (
        .clock, .rst_n, .alu_issue_valid, .mult_issue_valid, .issue,
        .alu_avail, .mult_avail, .cdb
    );

    // catch a result that is on the bus this very cycle
    assign opa_hit = cdb.valid && (cdb.dest_prn == src1_prn);
    assign opb_hit = cdb.valid && (cdb.dest_prn == src2_prn);

    always_comb begin
        rs_entry.op        = dispatch.op;
        rs_entry.opa_ready = rd1_ready || opa_hit;
        rs_entry.opa       = rd1_ready ? rd1_value : opa_hit ? cdb.value : XLEN'(src1_prn);
        rs_entry.opb_ready = rd2_ready || opb_hit;
        rs_entry.opb       = rd2_ready ? rd2_value : opb_hit ? cdb.value : XLEN'(src2_prn);
        rs_entry.imm       = dispatch.imm;
        rs_entry.dest_prn  = dest_prn;
        rs_entry.robn      = rob_tail;
    end

    assign rob_entry = '{dest_arn: dispatch.dest_arn, dest_prn: dest_prn,
                         old_prn: old_prn, done: 1'b0};

    assign commit = '{dest_arn: rob_commit.dest_arn, dest_prn: rob_commit.dest_prn,
                      old_prn: rob_commit.old_prn, value: commit_value};

    assign structural_hazard = rob_full || rs_full || free_empty;

endmodule

// ==== source/ooo_pkg.sv ====
package ooo_pkg;

    localparam int XLEN        = 16;
    localparam int ARCH_REG_SZ = 8;
    localparam int PHYS_REG_SZ = 16;
    localparam int ROB_SZ      = 8;
    localparam int RS_SZ       = 4;
    localparam int MULT_STAGES = 3;

    typedef logic [$clog2(ARCH_REG_SZ)-1:0] arn_t;
    typedef logic [$clog2(PHYS_REG_SZ)-1:0] prn_t;
    typedef logic [$clog2(ROB_SZ)-1:0]      robn_t;
    typedef logic [$clog2(RS_SZ)-1:0]       rs_idx_t;

    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef struct packed {
        op_e        op;
        arn_t       dest_arn;
        arn_t       src1_arn;
        arn_t       src2_arn;
        logic [7:0] imm;
    } dispatch_packet_t;

    // opa/opb hold the tag until the ready bit is set
    typedef struct packed {
        op_e             op;
        logic            opa_ready;
        logic [XLEN-1:0] opa;
        logic            opb_ready;
        logic [XLEN-1:0] opb;
        logic [7:0]      imm;
        prn_t            dest_prn;
        robn_t           robn;
    } rs_entry_t;

    typedef struct packed {
        op_e             op;
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
        logic [7:0]      imm;
        prn_t            dest_prn;
        robn_t           robn;
    } issue_packet_t;

    typedef struct packed {
        logic            valid;
        prn_t            dest_prn;
        robn_t           robn;
        logic [XLEN-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        arn_t dest_arn;
        prn_t dest_prn;
        prn_t old_prn;
        logic done;
    } rob_entry_t;

    typedef struct packed {
        arn_t            dest_arn;
        prn_t            dest_prn;
        prn_t            old_prn;
        logic [XLEN-1:0] value;
    } commit_packet_t;

endpackage

// ==== source/prf.sv ====
module prf (
    input  logic                      clock,
    input  logic                      rst_n,
    input  ooo_pkg::prn_t             rd1_prn,
    input  ooo_pkg::prn_t             rd2_prn,
    input  ooo_pkg::prn_t             commit_prn,
    input  ooo_pkg::prn_t             alloc_prn,
    input  logic                      alloc_valid,
    input  ooo_pkg::cdb_packet_t      cdb,
    output logic [ooo_pkg::XLEN-1:0]  rd1_value,
    output logic [ooo_pkg::XLEN-1:0]  rd2_value,
    output logic [ooo_pkg::XLEN-1:0]  commit_value,
    output logic                      rd1_ready,
    output logic                      rd2_ready
);
    import ooo_pkg::*;

    logic [XLEN-1:0]        values [PHYS_REG_SZ];
    logic [PHYS_REG_SZ-1:0] ready;

    assign rd1_value    = values[rd1_prn];
    assign rd2_value    = values[rd2_prn];
    assign commit_value = values[commit_prn];
    assign rd1_ready    = ready[rd1_prn];
    assign rd2_ready    = ready[rd2_prn];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ready <= '1;
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                values[i] <= '0;
            end
        end else begin
            if (alloc_valid) begin
                ready[alloc_prn] <= 1'b0;
            end
            if (cdb.valid) begin
                values[cdb.dest_prn] <= cdb.value;
                ready[cdb.dest_prn]  <= 1'b1;
            end
        end
    end

    // each tag is broadcast exactly once per allocation
    a_cdb_to_pending: assert property (@(posedge clock) disable iff (!rst_n)
        cdb.valid |-> !ready[cdb.dest_prn]);

endmodule

// ==== source/rat.sv ====
module rat (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      dispatch_valid,
    input  ooo_pkg::dispatch_packet_t dispatch,
    input  logic                      commit_valid,
    input  ooo_pkg::commit_packet_t   commit,
    output ooo_pkg::prn_t             src1_prn,
    output ooo_pkg::prn_t             src2_prn,
    output ooo_pkg::prn_t             old_prn,
    output ooo_pkg::prn_t             dest_prn,
    output logic                      free_empty
);
    import ooo_pkg::*;

    prn_t                           map_table [ARCH_REG_SZ];
    prn_t                           free_list [PHYS_REG_SZ];
    prn_t                           free_head;
    prn_t                           free_tail;
    logic [$clog2(PHYS_REG_SZ):0]   free_count;

    assign src1_prn   = map_table[dispatch.src1_arn];
    assign src2_prn   = map_table[dispatch.src2_arn];
    assign dest_prn   = free_list[free_head];
    assign free_empty = (free_count == 0);

    // r0 is never remapped, so its new register is simply handed back at commit
    assign old_prn = (dispatch.dest_arn == '0) ? free_list[free_head]
                                               : map_table[dispatch.dest_arn];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REG_SZ; i++) begin
                map_table[i] <= prn_t'(i);
            end
            for (int i = 0; i < PHYS_REG_SZ; i++) begin
                free_list[i] <= prn_t'(i + ARCH_REG_SZ);
            end
            free_head  <= '0;
            free_tail  <= prn_t'(PHYS_REG_SZ - ARCH_REG_SZ);
            free_count <= ($clog2(PHYS_REG_SZ)+1)'(PHYS_REG_SZ - ARCH_REG_SZ);
        end else begin
            if (dispatch_valid) begin
                free_head <= free_head + 1'b1;
                if (dispatch.dest_arn != '0) begin
                    map_table[dispatch.dest_arn] <= free_list[free_head];
                end
            end
            if (commit_valid) begin
                free_list[free_tail] <= commit.old_prn;
                free_tail            <= free_tail + 1'b1;
            end
            case ({dispatch_valid, commit_valid})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

    // the top must hold dispatch off while the list is empty
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_valid |-> free_count != 0);

    a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |-> free_count != PHYS_REG_SZ);

endmodule

// ==== source/rob.sv ====
module rob (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    dispatch_valid,
    input  ooo_pkg::rob_entry_t     entry_in,
    input  ooo_pkg::cdb_packet_t    cdb,
    output ooo_pkg::robn_t          tail,
    output logic                    full,
    output logic                    commit_valid,
    output ooo_pkg::commit_packet_t commit
);
    import ooo_pkg::*;

    rob_entry_t              entries [ROB_SZ];
    robn_t                   head;
    robn_t                   cdb_offset;
    logic [$clog2(ROB_SZ):0] count;

    assign full         = (count == ROB_SZ);
    assign commit_valid = (count != 0) && entries[head].done;

    // value comes from the register file at the top
    assign commit = '{dest_arn: entries[head].dest_arn, dest_prn: entries[head].dest_prn,
                      old_prn: entries[head].old_prn, value: '0};

    assign cdb_offset = cdb.robn - head;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (cdb.valid) begin
                entries[cdb.robn].done <= 1'b1;
            end
            if (dispatch_valid) begin
                entries[tail] <= entry_in;
                tail          <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            case ({dispatch_valid, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // completions only land between head and tail
    a_done_in_window: assert property (@(posedge clock) disable iff (!rst_n)
        cdb.valid |-> cdb_offset < count);

endmodule

// ==== source/rs.sv ====
module rs (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   dispatch_valid,
    input  ooo_pkg::rs_entry_t     entry_in,
    input  ooo_pkg::cdb_packet_t   cdb,
    input  logic                   alu_avail,
    input  logic                   mult_avail,
    output logic                   alu_issue_valid,
    output logic                   mult_issue_valid,
    output ooo_pkg::issue_packet_t issue,
    output logic                   full
);
    import ooo_pkg::*;

    rs_entry_t               entries [RS_SZ];
    rs_idx_t                 age [RS_SZ];
    logic [RS_SZ-1:0]        valid;
    logic [$clog2(RS_SZ):0]  count;
    rs_idx_t                 sel;
    rs_idx_t                 free_slot;
    logic                    sel_found;

    // age 0 is the oldest, ages stay dense over the valid entries
    always_comb begin
        count     = '0;
        free_slot = '0;
        sel       = '0;
        sel_found = 1'b0;
        for (int i = RS_SZ - 1; i >= 0; i--) begin
            if (valid[i]) begin
                count = count + 1'b1;
            end else begin
                free_slot = rs_idx_t'(i);
            end
        end
        for (int i = 0; i < RS_SZ; i++) begin
            if (valid[i] && entries[i].opa_ready && entries[i].opb_ready &&
                (entries[i].op == OP_MUL ? mult_avail : alu_avail) &&
                (!sel_found || age[i] < age[sel])) begin
                sel       = rs_idx_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign full             = (count == RS_SZ);
    assign alu_issue_valid  = sel_found && (entries[sel].op != OP_MUL);
    assign mult_issue_valid = sel_found && (entries[sel].op == OP_MUL);
    assign issue = '{op: entries[sel].op, opa: entries[sel].opa, opb: entries[sel].opb,
                     imm: entries[sel].imm, dest_prn: entries[sel].dest_prn,
                     robn: entries[sel].robn};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < RS_SZ; i++) begin
                if (valid[i]) begin
                    // wake-up from the bus
                    if (!entries[i].opa_ready && cdb.valid && prn_t'(entries[i].opa) == cdb.dest_prn) begin
                        entries[i].opa_ready <= 1'b1;
                        entries[i].opa       <= cdb.value;
                    end
                    if (!entries[i].opb_ready && cdb.valid && prn_t'(entries[i].opb) == cdb.dest_prn) begin
                        entries[i].opb_ready <= 1'b1;
                        entries[i].opb       <= cdb.value;
                    end
                    if (sel_found && age[i] > age[sel]) begin
                        age[i] <= age[i] - 1'b1;
                    end
                end
            end
            if (sel_found) begin
                valid[sel] <= 1'b0;
            end
            if (dispatch_valid) begin
                valid[free_slot]   <= 1'b1;
                entries[free_slot] <= entry_in;
                age[free_slot]     <= rs_idx_t'(count - sel_found);
            end
        end
    end

    a_no_dispatch_full: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_valid |-> !full);

endmodule

// ==== verif/ooo_tb.sv ====
module ooo_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int N_INSTR      = 300;
    localparam int TIMEOUT_NS   = N_INSTR * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic             clock = 1'b0;
    logic             rst_n;
    logic             dispatch_valid;
    dispatch_packet_t dispatch;
    logic             structural_hazard;
    logic             commit_valid;
    commit_packet_t   commit;

    logic [15:0]      lfsr = 16'd61;
    logic [XLEN-1:0]  arch_regs [ARCH_REG_SZ];
    arn_t             exp_arn [$];
    logic [XLEN-1:0]  exp_value [$];
    prn_t             rename_map [ARCH_REG_SZ];
    prn_t             free_prns [$];
    prn_t             exp_dest_prn [$];
    prn_t             exp_old_prn [$];
    int               errors        = 0;
    int               n_sent        = 0;
    int               n_committed   = 0;
    int               hazard_cycles = 0;
    int               r0_commits    = 0;
    int               in_rob;
    logic             last_sent     = 1'b0;
    logic             hazard_q      = 1'b1;
    arn_t             last_dest     = '0;

    ooo u_dut (
        .clock, .rst_n, .dispatch_valid, .dispatch,
        .structural_hazard, .commit_valid, .commit
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // mode 0 gives loads, 1 alu ops and 2 alu ops with multiply
    task automatic make_instr(input int mode, output dispatch_packet_t pkt);
        logic [15:0] v;
        take_bits(3, v);
        case (mode)
            0:       pkt.op = OP_LI;
            1:       pkt.op = op_e'({1'b0, v[1:0]});
            default: pkt.op = (v[2:0] > 3'd4) ? OP_MUL : op_e'(v[2:0]);
        endcase
        take_bits(3, v);
        pkt.dest_arn = arn_t'(v);
        take_bits(3, v);
        pkt.src1_arn = arn_t'(v);
        take_bits(3, v);
        pkt.src2_arn = arn_t'(v);
        take_bits(8, v);
        pkt.imm = v[7:0];
    endtask

    // in-order reference where r0 is never written
    function automatic void model_step(input dispatch_packet_t pkt);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [31:0]     prod;
        a    = arch_regs[pkt.src1_arn];
        b    = arch_regs[pkt.src2_arn];
        prod = a * b;
        case (pkt.op)
            OP_LI:   r = {8'h00, pkt.imm};
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_XOR:  r = a ^ b;
            default: r = prod[15:0];
        endcase
        exp_arn.push_back(pkt.dest_arn);
        exp_value.push_back(r);
        if (pkt.dest_arn != '0) begin
            arch_regs[pkt.dest_arn] = r;
        end
    endfunction

    // free list is a fifo and an r0 write gives its own register back
    function automatic void predict_rename(input dispatch_packet_t pkt);
        prn_t new_prn;
        new_prn = free_prns.pop_front();
        exp_dest_prn.push_back(new_prn);
        if (pkt.dest_arn == '0) begin
            exp_old_prn.push_back(new_prn);
        end else begin
            exp_old_prn.push_back(rename_map[pkt.dest_arn]);
            rename_map[pkt.dest_arn] = new_prn;
        end
    endfunction

    // safe when the station cannot fill or when nothing was added since hazard was low
    function automatic logic can_dispatch();
        return (n_sent - n_committed <= RS_SZ - 1) || (!last_sent && !hazard_q);
    endfunction

    task automatic idle_cycle();
        dispatch_valid <= 1'b0;
        last_sent = 1'b0;
        @(posedge clock);
    endtask

    task automatic send(input dispatch_packet_t pkt);
        while (!can_dispatch()) begin
            idle_cycle();
        end
        dispatch_valid <= 1'b1;
        dispatch       <= pkt;
        last_sent = 1'b1;
        n_sent++;
        model_step(pkt);
        predict_rename(pkt);
        @(posedge clock);
    endtask

    task automatic drain();
        idle_cycle();
        while (n_committed != n_sent) begin
            idle_cycle();
        end
    endtask

    task automatic run_phase(input int count, input int mode, input logic burst);
        dispatch_packet_t pkt;
        logic [15:0]      v;
        for (int i = 0; i < count; i++) begin
            if (!burst) begin
                take_bits(1, v);
                if (v[0]) begin
                    idle_cycle();
                end
            end
            make_instr(mode, pkt);
            // each burst instruction depends on the one before
            if (burst) begin
                pkt.src1_arn = last_dest;
            end
            last_dest = pkt.dest_arn;
            send(pkt);
        end
        drain();
    endtask

    task automatic check_quiet();
        assert (commit_valid === 1'b0) else begin
            $display("[FAIL] commit_valid got %h expected 0", commit_valid);
            errors++;
        end
        assert (structural_hazard === 1'b0) else begin
            $display("[FAIL] structural_hazard got %h expected 0", structural_hazard);
            errors++;
        end
    endtask

    task automatic check_commit();
        arn_t            want_arn;
        logic [XLEN-1:0] want_value;
        prn_t            want_dest_prn;
        prn_t            want_old_prn;
        n_committed++;
        assert (exp_arn.size() != 0) else begin
            $display("commit seen with no instruction outstanding in the model");
            errors++;
        end
        if (exp_arn.size() != 0) begin
            want_arn      = exp_arn.pop_front();
            want_value    = exp_value.pop_front();
            want_dest_prn = exp_dest_prn.pop_front();
            want_old_prn  = exp_old_prn.pop_front();
            free_prns.push_back(want_old_prn);
            if (want_arn == '0 && commit.dest_arn === '0) begin
                r0_commits++;
            end
            assert (commit.dest_arn == want_arn) else begin
                $display("[FAIL] commit.dest_arn got %h expected %h", commit.dest_arn, want_arn);
                errors++;
            end
            assert (commit.value == want_value) else begin
                $display("[FAIL] commit.value got %h expected %h", commit.value, want_value);
                errors++;
            end
            assert (commit.dest_prn == want_dest_prn) else begin
                $display("[FAIL] commit.dest_prn got %h expected %h",
                         commit.dest_prn, want_dest_prn);
                errors++;
            end
            assert (commit.old_prn == want_old_prn) else begin
                $display("[FAIL] commit.old_prn got %h expected %h",
                         commit.old_prn, want_old_prn);
                errors++;
            end
        end
    endtask

    // outputs only change on the rising edge
    always @(negedge clock) begin
        if (rst_n === 1'b1) begin
            hazard_q = structural_hazard;
            if (structural_hazard) begin
                hazard_cycles++;
            end
            if (dispatch_valid) begin
                assert (!structural_hazard) else begin
                    $display("dispatch strobed while structural_hazard was high");
                    errors++;
                end
            end
            in_rob = n_sent - int'(dispatch_valid) - n_committed;
            assert (in_rob <= ROB_SZ) else begin
                $display("%0d instructions in flight, more than the reorder buffer holds", in_rob);
                errors++;
            end
            if (commit_valid) begin
                check_commit();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns with %0d of %0d instructions committed",
                 TIMEOUT_NS, n_committed, N_INSTR);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int err0;
        int hz0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        for (int i = 0; i < ARCH_REG_SZ; i++) begin
            arch_regs[i]  = '0;
            rename_map[i] = prn_t'(i);
        end
        for (int i = ARCH_REG_SZ; i < PHYS_REG_SZ; i++) begin
            free_prns.push_back(prn_t'(i));
        end

        repeat (RESET_CYCLES - 1) begin
            @(negedge clock);
            check_quiet();
        end
        @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_quiet();
        // first idle cycle out of reset
        @(negedge clock);
        check_quiet();
        $display("test reset_quiet: %0d errors", errors);
        @(posedge clock);

        err0 = errors;
        run_phase(16, 0, 1'b0);
        $display("test li_run: 16 instructions, %0d errors", errors - err0);

        err0 = errors;
        run_phase(124, 1, 1'b0);
        $display("test alu_chains: 124 instructions, %0d errors", errors - err0);

        err0 = errors;
        run_phase(100, 2, 1'b0);
        $display("test mul_mix: 100 instructions, %0d errors", errors - err0);

        err0 = errors;
        hz0  = hazard_cycles;
        run_phase(60, 2, 1'b1);
        assert (hazard_cycles > hz0) else begin
            $display("structural_hazard never rose during the back-to-back burst");
            errors++;
        end
        assert (exp_arn.size() == 0 && n_committed == N_INSTR) else begin
            $display("%0d commits missing, %0d left in the model queue",
                     N_INSTR - n_committed, exp_arn.size());
            errors++;
        end
        $display("test burst: 60 instructions, %0d hazard cycles, %0d errors",
                 hazard_cycles - hz0, errors - err0);

        err0 = errors;
        assert (r0_commits > 0) else begin
            $display("no instruction wrote register 0");
            errors++;
        end
        $display("test r0_writes: %0d commits to register 0, %0d errors",
                 r0_commits, errors - err0);

        $display("summary: 6 tests, %0d dispatched, %0d committed, %0d errors",
                 n_sent, n_committed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
